//--- common/gauntlet_defs.svh
// Gauntlet I/O shared constants
// Download stream layout, program ROM map and game codes
`ifndef GAUNTLET_DEFS_SVH
`define GAUNTLET_DEFS_SVH

// ####################################################################
// Download stream
`define GIO_ADDR_W        25
`define GIO_IDX_ROM       8'd0     // ROM image bytes
`define GIO_IDX_GAME      8'd1     // game type byte
`define GIO_IDX_DIP       8'd254   // DIP switch bytes, addr 0..7

// ####################################################################
// Program ROM
`define GIO_PROG_AW       19       // CPU word address
`define GIO_BANK_AW_LARGE 15       // 32K words
`define GIO_BANK_AW_SMALL 14       // 16K words, 10A/10B pair
`define GIO_NUM_BANKS     6

// Download regions, matched against the upper byte address bits
`define GIO_REG_B0        9'h00C   // addr[24:16], 0C0000..0CFFFF
`define GIO_REG_B1        10'h01E  // addr[24:15], 0F0000..0F7FFF
`define GIO_REG_HI        7'h04    // addr[24:18], 100000..13FFFF, banks 2..5
`define GIO_GFX_LIMIT     25'h0C0000

// Graphics dword address
`define GIO_GFX_AW        23

// Slapstic / game codes
`define GIO_GAME_G1       8'd104   // Gauntlet
`define GIO_GAME_G2       8'd106   // Gauntlet II
`define GIO_GAME_G2P      8'd107   // 2-player Gauntlet
`define GIO_GAME_VIND     8'd118   // Vindicators Part II

`endif

//--- common/loader_pkg.sv
// Loader types
// Host download stream, program ROM write commands, graphics writes
`include "gauntlet_defs.svh"

package loader_pkg;

	typedef logic [7:0]                    load_index_t;
	typedef logic [`GIO_ADDR_W-1:0]        load_addr_t;   // byte address
	typedef logic [7:0]                    load_data_t;
	typedef logic [15:0]                   prog_word_t;
	typedef logic [`GIO_PROG_AW-1:0]       prog_addr_t;
	typedef logic [`GIO_NUM_BANKS-1:0]     bank_mask_t;   // one-hot
	typedef logic [`GIO_BANK_AW_LARGE-1:0] bank_addr_t;   // word in bank
	typedef logic [`GIO_GFX_AW-1:0]        gfx_addr_t;
	typedef logic [31:0]                   gfx_data_t;

	// Address and byte, the part of the stream the packer needs
	typedef struct packed {
		load_addr_t addr;
		load_data_t data;
	} load_payload_t;

	typedef struct packed {
		logic          download;   // download in progress
		logic          wr;         // byte strobe
		load_index_t   index;
		load_payload_t payload;
	} load_byte_t;

	typedef struct packed {
		bank_mask_t mask;
		bank_addr_t addr;
		prog_word_t word;
	} rom_wr_t;

	typedef struct packed {
		logic      stb;
		gfx_addr_t addr;
		gfx_data_t data;   // first byte in top bits
	} gfx_wr_t;

	typedef logic [7:0][7:0] dip_bank_t;   // byte n = DIP bank n

endpackage

//--- common/player_pkg.sv
// Player input types
// Key events, joysticks, active-low cabinet ports and game type
`include "gauntlet_defs.svh"

package player_pkg;

	typedef logic [8:0] key_code_t;   // extended flag in bit 8

	typedef struct packed {
		logic      toggle;    // flips on every event
		logic      pressed;
		key_code_t code;
	} key_event_t;

	// 0 right, 1 left, 2 down, 3 up, 7:4 buttons, 8 coin, 9 start
	typedef logic [15:0] joy_t;
	typedef logic [7:0]  player_port_t;   // active low
	typedef logic [4:0]  sys_port_t;      // service, coin1..coin4, active low

	typedef enum logic [7:0] {
		GAME_G1   = `GIO_GAME_G1,
		GAME_G2   = `GIO_GAME_G2,
		GAME_G2P  = `GIO_GAME_G2P,
		GAME_VIND = `GIO_GAME_VIND
	} game_type_e;

endpackage

//--- hw/rom_store/rom_bank.sv
// Program ROM bank
// Synchronous memory, one write port from the loader, one registered
// read port for the CPU
`timescale 1ns/1ps

module rom_bank
	import loader_pkg::*;
#(
	parameter int ADDR_W = 15
) (
	input  logic              clk_sys,
	input  logic              we,
	input  logic [ADDR_W-1:0] wr_addr,
	input  prog_word_t        wr_data,
	input  logic [ADDR_W-1:0] rd_addr,
	output prog_word_t        rd_data
);

	prog_word_t mem [2**ADDR_W];

	always_ff @(posedge clk_sys) begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// One cycle read latency
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- hw/rom_store/rom_store.sv
// Program ROM store
// Six banks written from the download stream, read by CPU word
// address with the bank select pipelined alongside the memory read
`timescale 1ns/1ps
`include "gauntlet_defs.svh"

module rom_store
	import loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  rom_wr_t    rom_wr,
	input  prog_addr_t rd_addr,
	output prog_word_t rd_data
);

	prog_word_t bank_q [`GIO_NUM_BANKS];
	bank_mask_t rd_sel;     // decode of the current address
	bank_mask_t rd_sel_q;   // lines up with bank_q

	// Bank 1 is the 16K word pair, the rest are 32K words
	for (genvar i = 0; i < `GIO_NUM_BANKS; i++) begin : g_bank
		localparam int AW = (i == 1) ? `GIO_BANK_AW_SMALL : `GIO_BANK_AW_LARGE;

		rom_bank #(
			.ADDR_W(AW)
		) u_bank (
			.clk_sys (clk_sys),
			.we      (rom_wr.mask[i]),
			.wr_addr (rom_wr.addr[AW-1:0]),
			.wr_data (rom_wr.word),
			.rd_addr (rd_addr[AW-1:0]),
			.rd_data (bank_q[i])
		);
	end

	// ####################################################################
	// CPU side map, word address bits 18:14
	always_comb begin
		rd_sel = '0;
		casez (rd_addr[`GIO_PROG_AW-1:14])
			5'b0000?: rd_sel[0] = 1'b1;   // 9A/9B
			5'b00110: rd_sel[1] = 1'b1;   // 10A/10B
			5'b0100?: rd_sel[2] = 1'b1;   // 7A/7B
			5'b0101?: rd_sel[3] = 1'b1;   // 6A/6B
			5'b0110?: rd_sel[4] = 1'b1;   // 5A/5B
			5'b0111?: rd_sel[5] = 1'b1;   // 3A/3B
			default:  rd_sel    = '0;     // unmapped reads zero
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			rd_sel_q <= '0;
		else
			rd_sel_q <= rd_sel;
	end

	always_comb begin
		rd_data = '0;
		for (int i = 0; i < `GIO_NUM_BANKS; i++) begin
			if (rd_sel_q[i])
				rd_data = rd_data | bank_q[i];
		end
	end

endmodule

//--- hw/load_control.sv
// Download decoder
// Splits the host byte stream into configuration writes, packing
// strobes and one-hot program ROM bank writes
`timescale 1ns/1ps
`include "gauntlet_defs.svh"

module load_control
	import loader_pkg::*;
	import player_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  load_byte_t load,
	input  prog_word_t prog_word,   // packed word from byte_packer
	output logic       byte_take,
	output logic       gfx_commit,
	output rom_wr_t    rom_wr,
	output game_type_e game_type,
	output dip_bank_t  dip_bank
);

	load_addr_t addr;
	bank_mask_t bank_hit;   // region decode, no strobe qualification
	logic       cfg_game;
	logic       cfg_dip;

	assign addr = load.payload.addr;

	// ####################################################################
	// Index 0, ROM image bytes
	assign byte_take  = load.wr & load.download & (load.index == `GIO_IDX_ROM);
	// Last byte of a dword in the graphics area
	assign gfx_commit = byte_take & (addr < `GIO_GFX_LIMIT) & (addr[1:0] == 2'b11);

	always_comb begin
		bank_hit    = '0;
		bank_hit[0] = (addr[`GIO_ADDR_W-1:16] == `GIO_REG_B0);
		bank_hit[1] = (addr[`GIO_ADDR_W-1:15] == `GIO_REG_B1);   // half size
		// 100000..13FFFF, one 64 KB bank per step of bits 17:16
		for (int i = 0; i < 4; i++) begin
			bank_hit[2 + i] = (addr[`GIO_ADDR_W-1:18] == `GIO_REG_HI) &&
				(addr[17:16] == 2'(i));
		end
	end

	// Word complete on the odd byte
	always_comb begin
		rom_wr.mask = (byte_take & addr[0]) ? bank_hit : '0;
		rom_wr.addr = addr[15:1];   // bank 1 uses the low 14 bits
		rom_wr.word = prog_word;
	end

	// ####################################################################
	// Configuration registers
	assign cfg_game = load.wr & (load.index == `GIO_IDX_GAME);
	assign cfg_dip  = load.wr & (load.index == `GIO_IDX_DIP) &
		(addr[`GIO_ADDR_W-1:3] == '0);   // only 0..7

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			game_type <= GAME_G1;
			dip_bank  <= '1;   // all switches off
		end else begin
			if (cfg_game)
				game_type <= game_type_e'(load.payload.data);
			if (cfg_dip)
				dip_bank[addr[2:0]] <= load.payload.data;
		end
	end

endmodule

//--- hw/byte_packer.sv
// Byte packer
// Keeps the last three download bytes, offers the 16-bit program word
// and registers completed 32-bit graphics words
`timescale 1ns/1ps

module byte_packer
	import loader_pkg::*;
(
	input  logic          clk_sys,
	input  logic          rst_n,
	input  logic          byte_take,
	input  logic          gfx_commit,
	input  load_payload_t data,        // byte with its address
	output prog_word_t    prog_word,
	output gfx_wr_t       gfx_wr
);

	logic [23:0] acc;   // previous bytes, newest in 7:0
	logic        gfx_stb;
	gfx_addr_t   gfx_addr;
	gfx_data_t   gfx_data;

	always_ff @(posedge clk_sys) begin
		if (byte_take)
			acc <= {acc[15:0], data.data};
	end

	assign prog_word = {acc[7:0], data.data};   // previous byte is high

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			gfx_stb <= 1'b0;
		else
			gfx_stb <= gfx_commit;   // single cycle pulse
	end

	always_ff @(posedge clk_sys) begin
		if (gfx_commit) begin
			gfx_addr <= data.addr[`GIO_ADDR_W-1:2];   // dword index
			gfx_data <= {acc, data.data};
		end
	end

	assign gfx_wr = '{stb: gfx_stb, addr: gfx_addr, data: gfx_data};

endmodule

//--- hw/player_input.sv
// Player input mapper
// Keyboard events through the Gauntlet or Vindicators key map,
// joystick tank steering, merged into active-low cabinet ports
`timescale 1ns/1ps

module player_input
	import player_pkg::*;
(
	input  logic               clk_sys,
	input  logic               rst_n,
	input  key_event_t         key,
	input  joy_t [3:0]         joy,
	input  logic               service,    // active high
	input  game_type_e         game_type,
	output player_port_t [3:0] player,
	output sys_port_t          sys
);

	logic               tog_q;      // toggle bit, last cycle
	logic               key_evt;
	logic               vind;       // Vindicators layout
	player_port_t [3:0] key_p;      // held keys, active high
	logic [3:0]         coin_key;   // coin1..coin4
	joy_t [3:0]         joy_q;
	logic [1:0][3:0]    steer_q;    // {x_bk, w_bk, x_fw, w_fw} per tank
	player_port_t [3:0] joy_p;      // joystick bits in port order

	// Eight-way stick to two tracks, W left and X right
	function automatic logic [3:0] steer(input logic [3:0] udlr);
		case (udlr)
			4'b1010: steer = 4'b0010;   // up left
			4'b1000: steer = 4'b0011;   // up
			4'b1001: steer = 4'b0001;   // up right
			4'b0001: steer = 4'b1001;   // right, spin
			4'b0101: steer = 4'b0100;   // down right
			4'b0100: steer = 4'b1100;   // down
			4'b0110: steer = 4'b1000;   // down left
			4'b0010: steer = 4'b0110;   // left, spin
			default: steer = 4'b0000;
		endcase
	endfunction

	assign vind    = (game_type == GAME_VIND);
	assign key_evt = key.toggle ^ tog_q;

	// ####################################################################
	// Keyboard
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			tog_q    <= 1'b0;
			key_p    <= '0;
			coin_key <= '0;
		end else begin
			tog_q <= key.toggle;
			if (key_evt && vind) begin
				case (key.code)
					9'h023: key_p[0][7] <= key.pressed;   // P1 R back (D)
					9'h01B: key_p[0][6] <= key.pressed;   // P1 L back (S)
					9'h024: key_p[0][5] <= key.pressed;   // P1 R forward (E)
					9'h01D: key_p[0][4] <= key.pressed;   // P1 L forward (W)
					9'h02D: key_p[0][3] <= key.pressed;   // P1 R thumb (R)
					9'h015: key_p[0][2] <= key.pressed;   // P1 L thumb (Q)
					9'h02B: key_p[0][1] <= key.pressed;   // P1 R trigger (F)
					9'h01C: key_p[0][0] <= key.pressed;   // P1 L trigger (A)
					9'h042: key_p[1][7] <= key.pressed;   // P2 R back (K)
					9'h03B: key_p[1][6] <= key.pressed;   // P2 L back (J)
					9'h043: key_p[1][5] <= key.pressed;   // P2 R forward (I)
					9'h03C: key_p[1][4] <= key.pressed;   // P2 L forward (U)
					9'h044: key_p[1][3] <= key.pressed;   // P2 R thumb (O)
					9'h035: key_p[1][2] <= key.pressed;   // P2 L thumb (Y)
					9'h04B: key_p[1][1] <= key.pressed;   // P2 R trigger (L)
					9'h033: key_p[1][0] <= key.pressed;   // P2 L trigger (H)
					9'h016: key_p[2][0] <= key.pressed;   // P1 start (1)
					9'h01E: key_p[2][1] <= key.pressed;   // P2 start (2)
					9'h02E: coin_key[0] <= key.pressed;   // coin1 (5)
					9'h036: coin_key[1] <= key.pressed;   // coin2 (6)
					default: ;
				endcase
			end else if (key_evt) begin
				case (key.code)
					9'h175: key_p[0][7] <= key.pressed;   // P1 up (up arrow)
					9'h172: key_p[0][6] <= key.pressed;   // P1 down (down arrow)
					9'h16B: key_p[0][5] <= key.pressed;   // P1 left (left arrow)
					9'h174: key_p[0][4] <= key.pressed;   // P1 right (right arrow)
					9'h014: key_p[0][1] <= key.pressed;   // P1 fire (left ctrl)
					9'h011: key_p[0][0] <= key.pressed;   // P1 magic (left alt)
					9'h02D: key_p[1][7] <= key.pressed;   // P2 up (R)
					9'h02B: key_p[1][6] <= key.pressed;   // P2 down (F)
					9'h023: key_p[1][5] <= key.pressed;   // P2 left (D)
					9'h034: key_p[1][4] <= key.pressed;   // P2 right (G)
					9'h01C: key_p[1][1] <= key.pressed;   // P2 fire (A)
					9'h01B: key_p[1][0] <= key.pressed;   // P2 magic (S)
					9'h043: key_p[2][7] <= key.pressed;   // P3 up (I)
					9'h042: key_p[2][6] <= key.pressed;   // P3 down (K)
					9'h03B: key_p[2][5] <= key.pressed;   // P3 left (J)
					9'h04B: key_p[2][4] <= key.pressed;   // P3 right (L)
					9'h114: key_p[2][1] <= key.pressed;   // P3 fire (right ctrl)
					9'h059: key_p[2][0] <= key.pressed;   // P3 magic (right shift)
					9'h075: key_p[3][7] <= key.pressed;   // P4 up (keypad 8)
					9'h072: key_p[3][6] <= key.pressed;   // P4 down (keypad 2)
					9'h06B: key_p[3][5] <= key.pressed;   // P4 left (keypad 4)
					9'h074: key_p[3][4] <= key.pressed;   // P4 right (keypad 6)
					9'h070: key_p[3][1] <= key.pressed;   // P4 fire (keypad 0)
					9'h071: key_p[3][0] <= key.pressed;   // P4 magic (keypad .)
					9'h02E: coin_key[0] <= key.pressed;   // coin1 (5)
					9'h036: coin_key[1] <= key.pressed;   // coin2 (6)
					9'h03D: coin_key[2] <= key.pressed;   // coin3 (7)
					9'h03E: coin_key[3] <= key.pressed;   // coin4 (8)
					default: ;
				endcase
			end
		end
	end

	// ####################################################################
	// Joysticks, steering registered after the stick sample
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			joy_q   <= '0;
			steer_q <= '0;
		end else begin
			joy_q      <= joy;
			steer_q[0] <= steer(joy_q[0][3:0]);
			steer_q[1] <= steer(joy_q[1][3:0]);
		end
	end

	always_comb begin
		if (vind) begin
			joy_p[0] = {steer_q[0], joy_q[0][7:4]};
			joy_p[1] = {steer_q[1], joy_q[1][7:4]};
			joy_p[2] = {6'b0, joy_q[1][9], joy_q[0][9]};   // starts
			joy_p[3] = '0;
		end else begin
			for (int i = 0; i < 4; i++)
				joy_p[i] = {joy_q[i][3:0], joy_q[i][7:4]};   // up in bit 7
		end
		for (int i = 0; i < 4; i++)
			player[i] = ~(key_p[i] | joy_p[i]);
	end

	assign sys = {~service,
		~(coin_key[0] | joy_q[0][8]),
		~(coin_key[1] | joy_q[1][8]),
		~(coin_key[2] | joy_q[2][8]),
		~(coin_key[3] | joy_q[3][8])};

endmodule

//--- hw/gauntlet_io.sv
// Gauntlet I/O top
// Download decode, byte packing, program ROM and player input
// mapping for the Gauntlet board port
`timescale 1ns/1ps

module gauntlet_io
	import loader_pkg::*;
	import player_pkg::*;
(
	input  logic               clk_sys,
	input  logic               rst_n,
	input  load_byte_t         load,
	input  prog_addr_t         prog_addr,
	output prog_word_t         prog_data,
	output gfx_wr_t            gfx_wr,
	input  key_event_t         key,
	input  joy_t [3:0]         joy,
	input  logic               service,
	output player_port_t [3:0] player,
	output sys_port_t          sys,
	output game_type_e         game_type,
	output dip_bank_t          dip_bank
);

	logic       byte_take;
	logic       gfx_commit;
	prog_word_t prog_word;   // packer to ROM write path
	rom_wr_t    rom_wr;

	load_control u_load_control (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.load       (load),
		.prog_word  (prog_word),
		.byte_take  (byte_take),
		.gfx_commit (gfx_commit),
		.rom_wr     (rom_wr),
		.game_type  (game_type),
		.dip_bank   (dip_bank)
	);

	byte_packer u_byte_packer (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.byte_take  (byte_take),
		.gfx_commit (gfx_commit),
		.data       (load.payload),
		.prog_word  (prog_word),
		.gfx_wr     (gfx_wr)
	);

	rom_store u_rom_store (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.rom_wr  (rom_wr),
		.rd_addr (prog_addr),
		.rd_data (prog_data)
	);

	player_input u_player_input (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.key       (key),
		.joy       (joy),
		.service   (service),
		.game_type (game_type),
		.player    (player),
		.sys       (sys)
	);

endmodule

//--- sim/tb_gauntlet_io.sv
// Gauntlet I/O testbench
// Directed tests for reset state, configuration, program ROM,
// graphics packing, key maps and joystick steering
`timescale 1ns/1ps
`include "gauntlet_defs.svh"

module tb_gauntlet_io
	import loader_pkg::*;
	import player_pkg::*;
();

	localparam int CLK_NS      = 40;
	// Reset, config, ROM, gfx, keys, joysticks
	localparam int RUN_CYCLES  = 20 + 40 + 330 + 40 + 60 + 160;
	localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_NS;   // double for margin

	logic               clk_sys;
	logic               rst_n;
	load_byte_t         load;
	prog_addr_t         prog_addr;
	prog_word_t         prog_data;
	gfx_wr_t            gfx_wr;
	key_event_t         key;
	joy_t [3:0]         joy;
	logic               service;
	player_port_t [3:0] player;
	sys_port_t          sys;
	game_type_e         game_type;
	dip_bank_t          dip_bank;

	int          errors;
	int          tests;
	logic [31:0] lcg_state;

	gauntlet_io u_dut (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.load      (load),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.gfx_wr    (gfx_wr),
		.key       (key),
		.joy       (joy),
		.service   (service),
		.player    (player),
		.sys       (sys),
		.game_type (game_type),
		.dip_bank  (dip_bank)
	);

	always #(CLK_NS / 2) clk_sys = ~clk_sys;

	// ####################################################################
	// Helpers
	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];   // upper bits spread better
	endfunction

	// Tank tracks {x_bk, w_bk, x_fw, w_fw} with W left and X right
	function automatic logic [3:0] track_steer(input logic [3:0] udlr);
		logic up, dn, lt, rt, still;
		{up, dn, lt, rt} = udlr;
		still = ~up & ~dn;   // pure left or right spins in place
		track_steer[0] = (up & ~lt) | (rt & still);
		track_steer[1] = (up & ~rt) | (lt & still);
		track_steer[2] = (dn & ~lt) | (lt & still);
		track_steer[3] = (dn & ~rt) | (rt & still);
	endfunction

	// Region starts in the download map
	function automatic load_addr_t bank_load_base(input int b);
		case (b)
			0:       return 25'h0C0000;
			1:       return 25'h0F0000;
			default: return 25'h100000 + 25'(b - 2) * 25'h10000;
		endcase
	endfunction

	// CPU word address of the first word per the bits 18:14 map
	function automatic prog_addr_t bank_read_base(input int b);
		case (b)
			0:       return 19'h00000;
			1:       return 19'h18000;
			default: return 19'h20000 + 19'(b - 2) * 19'h08000;
		endcase
	endfunction

	task automatic mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		errors++;
		$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		if (errors == err_start)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - err_start);
	endtask

	// One strobe cycle, then strobe low for a cycle
	task automatic send_byte(input load_index_t idx, input load_addr_t addr,
		input load_data_t data);
		@(posedge clk_sys);
		load <= '{download: 1'b1, wr: 1'b1, index: idx,
			payload: '{addr: addr, data: data}};
		@(posedge clk_sys);
		load.wr <= 1'b0;
	endtask

	task automatic send_word(input load_addr_t addr, input prog_word_t word);
		send_byte(`GIO_IDX_ROM, addr, word[15:8]);       // high byte first
		send_byte(`GIO_IDX_ROM, addr + 25'd1, word[7:0]);
	endtask

	task automatic set_game(input logic [7:0] code);
		send_byte(`GIO_IDX_GAME, '0, code);
		@(negedge clk_sys);
		if (game_type !== code)
			mismatch("game_type", game_type, code);
	endtask

	task automatic key_event(input key_code_t code, input logic pressed);
		@(posedge clk_sys);
		key <= '{toggle: ~key.toggle, pressed: pressed, code: code};
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// Negative port means the code must not touch any port
	task automatic check_key(input key_code_t code, input int port, input int bit_no);
		player_port_t [3:0] want;
		want = {4{8'hFF}};
		if (port >= 0)
			want[port][bit_no] = 1'b0;
		key_event(code, 1'b1);
		if (player !== want)
			mismatch($sformatf("player, key %0h down", code), player, want);
		key_event(code, 1'b0);
		if (player !== {4{8'hFF}})
			mismatch($sformatf("player, key %0h up", code), player, {4{8'hFF}});
	endtask

	task automatic check_coin(input key_code_t code, input int sys_bit);
		sys_port_t want;
		want = 5'h1F;
		want[sys_bit] = 1'b0;
		key_event(code, 1'b1);
		if (sys !== want)
			mismatch($sformatf("sys, key %0h down", code), sys, want);
		key_event(code, 1'b0);
		if (sys !== 5'h1F)
			mismatch($sformatf("sys, key %0h up", code), sys, 5'h1F);
	endtask

	task automatic drive_joy(input int i, input joy_t v);
		@(posedge clk_sys);
		joy[i] <= v;
		repeat (4) @(posedge clk_sys);   // covers the steering stage
		@(negedge clk_sys);
	endtask

	// ####################################################################
	// Tests
	task automatic test_reset_state();
		int err_start;
		err_start = errors;
		@(negedge clk_sys);
		if (gfx_wr.stb !== 1'b0)
			mismatch("gfx_wr.stb", gfx_wr.stb, 1'b0);
		if (game_type !== `GIO_GAME_G1)
			mismatch("game_type", game_type, `GIO_GAME_G1);
		if (dip_bank !== 64'hFFFF_FFFF_FFFF_FFFF)
			mismatch("dip_bank", dip_bank, 64'hFFFF_FFFF_FFFF_FFFF);
		if (player !== {4{8'hFF}})
			mismatch("player", player, {4{8'hFF}});
		if (sys !== 5'h1F)
			mismatch("sys", sys, 5'h1F);
		@(posedge clk_sys);
		service <= 1'b1;
		@(negedge clk_sys);
		if (sys !== 5'h0F)   // service is bit 4
			mismatch("sys", sys, 5'h0F);
		@(posedge clk_sys);
		service <= 1'b0;
		end_test("reset_state", err_start);
	endtask

	task automatic test_config();
		int        err_start;
		dip_bank_t dip_want;
		err_start = errors;
		set_game(`GIO_GAME_G2);
		dip_want = '1;
		for (int i = 0; i < 8; i++) begin
			dip_want[i] = rand_byte();
			send_byte(`GIO_IDX_DIP, 25'(i), dip_want[i]);
			@(negedge clk_sys);
			if (dip_bank !== dip_want)
				mismatch("dip_bank", dip_bank, dip_want);
		end
		// One past the DIP bytes
		send_byte(`GIO_IDX_DIP, 25'd8, 8'h5A);
		@(negedge clk_sys);
		if (dip_bank !== dip_want)
			mismatch("dip_bank", dip_bank, dip_want);
		set_game(`GIO_GAME_G1);
		end_test("config", err_start);
	endtask

	task automatic test_prog_rom();
		int         err_start;
		int         offs;
		prog_word_t word;
		prog_addr_t rd_q [$];
		prog_word_t want_q [$];
		err_start = errors;
		// Banks interleaved so the reads hop banks every cycle
		for (int j = 0; j < 9; j++) begin
			for (int b = 0; b < `GIO_NUM_BANKS; b++) begin
				offs = (j < 8) ? j * 32'h0801 : ((b == 1) ? 32'h3FFF : 32'h7FFF);
				word = {rand_byte(), rand_byte()};
				send_word(bank_load_base(b) + 25'(2 * offs), word);
				rd_q.push_back(bank_read_base(b) + 19'(offs));
				want_q.push_back(word);
			end
		end
		// Filler region must not alias into bank 0
		for (int j = 0; j < 8; j++)
			send_word(25'h0D0000 + 25'(2 * j * 32'h0801), {rand_byte(), rand_byte()});
		foreach (rd_q[i]) begin
			if (i % 12 == 5) begin
				rd_q.insert(i, 19'h08000 + 19'(i));   // unmapped holes
				want_q.insert(i, 16'h0000);
			end
		end
		rd_q.push_back(19'h1C000);
		want_q.push_back(16'h0000);
		rd_q.push_back(19'h7FFFF);
		want_q.push_back(16'h0000);
		// Pipelined reads with each result checked the cycle after its address
		for (int i = 0; i <= rd_q.size(); i++) begin
			@(posedge clk_sys);
			if (i < rd_q.size())
				prog_addr <= rd_q[i];
			@(negedge clk_sys);
			if (i > 0 && prog_data !== want_q[i - 1])
				mismatch($sformatf("prog_data @%0h", rd_q[i - 1]), prog_data, want_q[i - 1]);
		end
		end_test("prog_rom", err_start);
	endtask

	task automatic test_gfx_pack();
		int          err_start;
		gfx_addr_t   dw [3];
		logic [7:0]  b [4];
		err_start = errors;
		dw = '{23'h0, 23'h5, 23'h2FFFF};   // last one at the area top
		foreach (dw[k]) begin
			for (int i = 0; i < 4; i++) begin
				b[i] = rand_byte();
				send_byte(`GIO_IDX_ROM, {dw[k], 2'(i)}, b[i]);
				@(negedge clk_sys);
				if (i < 3 && gfx_wr.stb !== 1'b0)
					mismatch("gfx_wr.stb", gfx_wr.stb, 1'b0);
			end
			if (gfx_wr.stb !== 1'b1)
				mismatch("gfx_wr.stb", gfx_wr.stb, 1'b1);
			if (gfx_wr.addr !== dw[k])
				mismatch("gfx_wr.addr", gfx_wr.addr, dw[k]);
			if (gfx_wr.data !== {b[0], b[1], b[2], b[3]})
				mismatch("gfx_wr.data", gfx_wr.data, {b[0], b[1], b[2], b[3]});
		end
		// Dword end just above the graphics area
		send_byte(`GIO_IDX_ROM, 25'h0C0003, rand_byte());
		@(negedge clk_sys);
		if (gfx_wr.stb !== 1'b0)
			mismatch("gfx_wr.stb", gfx_wr.stb, 1'b0);
		end_test("gfx_pack", err_start);
	endtask

	task automatic test_key_maps();
		int err_start;
		err_start = errors;
		check_key(9'h175, 0, 7);    // P1 up
		check_key(9'h011, 0, 0);    // P1 magic
		check_key(9'h034, 1, 4);    // P2 right
		check_key(9'h114, 2, 1);    // P3 fire
		check_key(9'h072, 3, 6);    // P4 down
		check_coin(9'h02E, 3);      // coin1
		check_coin(9'h03E, 0);      // coin4
		set_game(`GIO_GAME_VIND);
		check_key(9'h023, 0, 7);    // P1 right track back
		check_key(9'h03C, 1, 4);    // P2 left track forward
		check_key(9'h016, 2, 0);    // P1 start
		check_key(9'h01E, 2, 1);    // P2 start
		check_key(9'h175, -1, 0);   // arrow key unused here
		check_coin(9'h036, 2);      // coin2
		end_test("key_maps", err_start);
	endtask

	task automatic test_joystick();
		int           err_start;
		joy_t         stick;
		player_port_t want;
		logic [3:0]   dirs [9];
		err_start = errors;
		set_game(`GIO_GAME_G1);
		for (int i = 0; i < 4; i++) begin
			stick = {8'h00, rand_byte()};
			drive_joy(i, stick);
			want[7]   = ~stick[3];     // up
			want[6]   = ~stick[2];     // down
			want[5]   = ~stick[1];     // left
			want[4]   = ~stick[0];     // right
			want[3:0] = ~stick[7:4];   // buttons
			if (player[i] !== want)
				mismatch($sformatf("player[%0d]", i), player[i], want);
			drive_joy(i, '0);
		end
		drive_joy(2, 16'h0100);   // coin3 from stick
		if (sys !== 5'h1D)
			mismatch("sys", sys, 5'h1D);
		drive_joy(2, '0);
		set_game(`GIO_GAME_VIND);
		// Centre and the eight directions as {up, down, left, right}
		dirs = '{4'b0000, 4'b1000, 4'b1001, 4'b0001, 4'b0101,
			4'b0100, 4'b0110, 4'b0010, 4'b1010};
		foreach (dirs[d]) begin
			drive_joy(0, {12'h000, dirs[d]});
			drive_joy(1, {12'h000, dirs[d]});
			want = ~{track_steer(dirs[d]), 4'b0000};
			if (player[0] !== want)
				mismatch($sformatf("player[0] dir %b", dirs[d]), player[0], want);
			if (player[1] !== want)
				mismatch($sformatf("player[1] dir %b", dirs[d]), player[1], want);
		end
		drive_joy(0, 16'h0200);   // start 1
		if (player[2] !== 8'hFE)
			mismatch("player[2]", player[2], 8'hFE);
		drive_joy(0, '0);
		end_test("joystick", err_start);
	endtask

	// ####################################################################
	// Sequence
	initial begin
		clk_sys   = 1'b0;
		rst_n     = 1'b0;
		load      = '0;
		prog_addr = '0;
		key       = '0;
		joy       = '0;
		service   = 1'b0;
		errors    = 0;
		tests     = 0;
		lcg_state = 32'hbd0d;
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
		test_reset_state();
		test_config();
		test_prog_rom();
		test_gfx_pack();
		test_key_maps();
		test_joystick();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

endmodule

//--- gauntlet_io.f
+incdir+common
common/loader_pkg.sv
common/player_pkg.sv
hw/rom_store/rom_bank.sv
hw/rom_store/rom_store.sv
hw/load_control.sv
hw/byte_packer.sv
hw/player_input.sv
hw/gauntlet_io.sv
sim/tb_gauntlet_io.sv

//--- Bender.yml
package:
  name: gauntlet_io

export_include_dirs:
  - common

sources:
  - common/loader_pkg.sv
  - common/player_pkg.sv
  - hw/rom_store/rom_bank.sv
  - hw/rom_store/rom_store.sv
  - hw/load_control.sv
  - hw/byte_packer.sv
  - hw/player_input.sv
  - hw/gauntlet_io.sv
  - target: test
    files:
      - sim/tb_gauntlet_io.sv
